//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = media_loader_tb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- filelist.f
rtl/ioctl_pkg.sv
rtl/rom_pkg.sv
rtl/rom_header_check.sv
rtl/cart_loader.sv
rtl/cheat_code_loader.sv
rtl/media_loader.sv
tests/media_loader_asserts.sv
tests/media_loader_tb.sv

//--- rtl/cart_loader.sv
// Host must hold ioctl_wr low while ioctl_wait is high; a write on the start cycle is dropped
module cart_loader (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic                           ioctl_download,
	input  logic [ioctl_pkg::INDEX_W-1:0]  ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [ioctl_pkg::DATA_W-1:0]   ioctl_dout,
	input  logic                           swap_bytes,
	input  logic                           ack_ddr,
	input  logic                           ack_sdr,
	output logic                           ioctl_wait,
	output logic [rom_pkg::ROM_AW-1:0]     rom_addr,
	output logic [ioctl_pkg::DATA_W-1:0]   rom_data,
	output logic                           rom_req,
	output logic [1:0]                     pop_flags,
	output logic                           sgx
);

	import ioctl_pkg::*;
	import rom_pkg::*;

	logic cart_download;
	logic cart_download_q;
	logic cart_start;
	logic cart_wr;
	logic acked;

	// ========================================================================
	// Download qualification
	// ========================================================================
	assign cart_download = ioctl_download && (ioctl_index != CODE_INDEX);
	assign cart_start    = cart_download && !cart_download_q;	// Rising edge
	assign cart_wr       = ioctl_wr && cart_download;

	// Both back-ends caught up with the request toggle
	assign acked = (rom_req == ack_ddr) && (rom_req == ack_sdr);

	// Bit reverse inside each byte, byte lanes stay put
	always_comb begin
		rom_data = ioctl_dout;
		if (swap_bytes) begin
			for (int i = 0; i < 8; i++) begin
				rom_data[i]     = ioctl_dout[7-i];
				rom_data[8+i]   = ioctl_dout[15-i];
			end
		end
	end

	// ========================================================================
	// Request sequencing and address counter
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_download_q <= 1'b0;
			ioctl_wait      <= 1'b0;
			rom_req         <= 1'b0;
			rom_addr        <= '0;
			sgx             <= 1'b0;
		end else begin
			cart_download_q <= cart_download;

			if (cart_start) begin
				rom_addr <= '0;
				sgx      <= (ioctl_index[4:0] == SGX_INDEX);
			end else if (cart_wr) begin
				ioctl_wait <= 1'b1;	// Hold host until both acks
				rom_req    <= ~rom_req;
			end else if (ioctl_wait && acked) begin
				ioctl_wait <= 1'b0;
				rom_addr   <= rom_addr + 2'd2;	// Next word
			end
		end
	end

	// Signature check sees the same data and address as the ROM
	rom_header_check u_header_check (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.start     (cart_start),
		.wr        (cart_wr),
		.addr      (rom_addr),
		.data      (rom_data),
		.pop_flags (pop_flags)
	);

endmodule

//--- rtl/cheat_code_loader.sv
// Records are 16 bytes on 16-byte boundaries; address bit 0 is ignored and code holds no reset value
module cheat_code_loader (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic                           ioctl_download,
	input  logic [ioctl_pkg::INDEX_W-1:0]  ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [ioctl_pkg::ADDR_W-1:0]   ioctl_addr,
	input  logic [ioctl_pkg::DATA_W-1:0]   ioctl_dout,
	output ioctl_pkg::cheat_code_t         code,
	output logic                           code_valid,
	output logic                           code_reset
);

	import ioctl_pkg::*;

	logic       code_download;
	logic       code_wr;
	logic [2:0] slot;

	assign code_download = ioctl_download && (ioctl_index == CODE_INDEX);
	assign code_wr       = code_download && ioctl_wr;
	assign slot          = code_slot(ioctl_addr[3:0]);

	// ========================================================================
	// Record assembly
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			code.word[slot] <= ioctl_dout;
		end
	end

	// Strobes
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			// Replace high half closes the record
			code_valid <= code_wr && (ioctl_addr[3:0] == CODE_LAST_OFS);

			// Any download restarting at 0 flushes the cheat list
			code_reset <= ioctl_download && ioctl_wr && (ioctl_addr == '0);
		end
	end

endmodule

//--- rtl/ioctl_pkg.sv
// Host download bus definitions; the code index is all ones, cheat words arrive at even offsets
package ioctl_pkg;

	// ========================================================================
	// Host transfer widths
	// ========================================================================
	localparam int DATA_W  = 16;
	localparam int ADDR_W  = 25;
	localparam int INDEX_W = 8;

	localparam logic [INDEX_W-1:0] CODE_INDEX = '1;	// Marks a code download
	localparam logic [3:0] CODE_LAST_OFS = 4'd14;	// Last word of a record

	// ========================================================================
	// Cheat record, written as words and read as fields
	// ========================================================================
	typedef union packed {
		logic [7:0][15:0] word;	// Word k at bit 16k
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} field;
	} cheat_code_t;

	// Byte offset to word slot
	// Halve the offset, then flip its top two bits so each low half lands below its high half
	function automatic logic [2:0] code_slot(input logic [3:0] offset);
		return {~offset[3:2], offset[1]};
	endfunction

endpackage

//--- rtl/media_loader.sv
// Download front end; ack_ddr and ack_sdr must be toggles from back-ends in the clk_sys domain
module media_loader (
	input  logic                           clk_sys,
	input  logic                           rst,

	// Host side
	input  logic                           ioctl_download,
	input  logic [ioctl_pkg::INDEX_W-1:0]  ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [ioctl_pkg::ADDR_W-1:0]   ioctl_addr,
	input  logic [ioctl_pkg::DATA_W-1:0]   ioctl_dout,
	input  logic                           swap_bytes,
	output logic                           ioctl_wait,

	// Storage side
	output logic [rom_pkg::ROM_AW-1:0]     rom_addr,
	output logic [ioctl_pkg::DATA_W-1:0]   rom_data,
	output logic                           rom_req,
	input  logic                           ack_ddr,
	input  logic                           ack_sdr,

	// Flags and cheats
	output logic [1:0]                     pop_flags,
	output logic                           sgx,
	output ioctl_pkg::cheat_code_t         code,
	output logic                           code_valid,
	output logic                           code_reset
);

	// ========================================================================
	// Cartridge path
	// ========================================================================
	cart_loader u_cart_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.swap_bytes     (swap_bytes),
		.ack_ddr        (ack_ddr),
		.ack_sdr        (ack_sdr),
		.ioctl_wait     (ioctl_wait),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.rom_req        (rom_req),
		.pop_flags      (pop_flags),
		.sgx            (sgx)
	);

	// Code path, never stalls the host
	cheat_code_loader u_cheat_code_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.code           (code),
		.code_valid     (code_valid),
		.code_reset     (code_reset)
	);

endmodule

//--- rtl/rom_header_check.sv
// Checks write data against the signature using the loader's own counter address; start wins over wr
module rom_header_check (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic                          start,
	input  logic                          wr,
	input  logic [rom_pkg::ROM_AW-1:0]    addr,
	input  logic [ioctl_pkg::DATA_W-1:0]  data,
	output logic [1:0]                    pop_flags
);

	import rom_pkg::*;

	logic       in_page;
	logic       sig_ofs;
	logic [2:0] sig_word_idx;
	logic [1:0] sig_sel;
	logic       bank;
	logic       mismatch;

	// ========================================================================
	// Header page and signature slot decode
	// ========================================================================
	always_comb begin
		in_page = (addr[ROM_AW-1:4] == HDR_PAGE_A) ||
			(addr[ROM_AW-1:4] == HDR_PAGE_B);

		// Even bytes 6..12 only
		sig_ofs = !addr[0] && (addr[3:1] >= SIG_FIRST) && (addr[3:1] <= SIG_LAST);

		sig_word_idx = addr[3:1] - SIG_FIRST;
		sig_sel      = sig_word_idx[1:0];	// 0..3 inside the window

		bank     = addr[13];	// Page 0x1F2 has it clear, 0x212 set
		mismatch = wr && in_page && sig_ofs && (data != SIG_WORD[sig_sel]);
	end

	// ========================================================================
	// Flags
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pop_flags <= 2'b00;
		end else if (start) begin
			pop_flags <= 2'b11;	// Assume both banks until proven otherwise
		end else if (mismatch) begin
			pop_flags[bank] <= 1'b0;
		end
	end

endmodule

//--- rtl/rom_pkg.sv
// ROM image constants; the header signature is checked only in two fixed 16-byte pages
package rom_pkg;

	// ========================================================================
	// ROM addressing
	// ========================================================================
	localparam int ROM_AW = 24;	// Byte address

	// Header pages on address bits 23:4
	localparam logic [ROM_AW-5:0] HDR_PAGE_A = 20'h1F2;	// Bank 0
	localparam logic [ROM_AW-5:0] HDR_PAGE_B = 20'h212;	// Bank 1

	// ========================================================================
	// Two-bank signature
	// ========================================================================
	// Word offsets of the first and last signature word, bytes 6 and 12
	localparam logic [2:0] SIG_FIRST = 3'd3;
	localparam logic [2:0] SIG_LAST  = 3'd6;

	// Expected words for bytes 6, 8, 10, 12
	localparam logic [0:3][15:0] SIG_WORD = {
		16'h4F50,
		16'h5550,
		16'h4F4C,
		16'h5355
	};

	// SuperGrafx download slot, index bits 4:0
	localparam logic [4:0] SGX_INDEX = 5'd2;

endpackage

//--- tests/media_loader_asserts.sv
// Protocol checks; bound twice, unused inputs of each binding are tied low
module media_loader_asserts (
	input logic clk_sys,
	input logic rst,
	input logic cart_wr,
	input logic ioctl_wait,
	input logic rom_req,
	input logic code_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// Wait only rises after a cartridge write
	wait_rise: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(ioctl_wait) |-> $past(cart_wr))
		else $error("ioctl_wait rose without a cartridge write");

	req_toggle: assert property (@(posedge clk_sys) disable iff (rst)
		(rom_req != $past(rom_req)) |-> $past(cart_wr))
		else $error("rom_req toggled without a cartridge write");

	valid_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		code_valid |=> !code_valid)
		else $error("code_valid held for two cycles");

endmodule

bind cart_loader media_loader_asserts u_cart_asserts (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.cart_wr    (cart_wr),
	.ioctl_wait (ioctl_wait),
	.rom_req    (rom_req),
	.code_valid (1'b0)
);

bind cheat_code_loader media_loader_asserts u_code_asserts (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.cart_wr    (1'b0),
	.ioctl_wait (1'b0),
	.rom_req    (1'b0),
	.code_valid (code_valid)
);

//--- tests/media_loader_tb.sv
// Testbench for media_loader; cart words stream through filler writes to reach header pages
module media_loader_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [1:0] K_CART_START = 2'd0;
	localparam logic [1:0] K_CART_WORD  = 2'd1;
	localparam logic [1:0] K_CODE_START = 2'd2;
	localparam logic [1:0] K_CODE_WORD  = 2'd3;
	localparam int ROWS = 20;
	localparam int RESET_CYCLES = 10;

	typedef struct packed {
		logic [1:0]  kind;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        swap;
		logic [15:0] exp_data;	// Expected rom_data
		logic [1:0]  exp_flags;
		logic        exp_bit;	// sgx on start, code_valid on code word
	} row_t;

	logic clk_sys, rst;
	logic ioctl_download, ioctl_wr, swap_bytes, ack_ddr, ack_sdr;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wait, rom_req, sgx, code_valid, code_reset;
	logic [23:0] rom_addr;
	logic [15:0] rom_data;
	logic [1:0] pop_flags;
	ioctl_pkg::cheat_code_t code;

	row_t table_rows [ROWS];
	int cycle_count = 0;
	int cycle_limit = 0;
	int valid_count = 0;
	logic [23:0] model_addr;

	media_loader DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Acknowledge models, each echoes rom_req after 0 to 5 cycles
	// ========================================================================
	initial begin : ddr_model
		int delay;
		ack_ddr = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (ack_ddr != rom_req) begin
				delay = $urandom % 6;
				repeat (delay) @(negedge clk_sys);
				ack_ddr = rom_req;
			end
		end
	end

	initial begin : sdr_model
		int delay;
		ack_sdr = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (ack_sdr != rom_req) begin
				delay = $urandom % 6;
				repeat (delay) @(negedge clk_sys);
				ack_sdr = rom_req;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (code_valid)
			valid_count <= valid_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %s got %h expected %h", name, got, exp);
		$display("** FAIL **");
		$fatal(1, "check failed");
	endtask

	task automatic load_table();
		// Signature inputs are bit-reversed inside each byte so the swapped data matches
		table_rows[0]  = '{K_CART_START, 8'd2, 25'h0, 16'h0, 1'b0, 16'h0, 2'b11, 1'b1};
		table_rows[1]  = '{K_CART_WORD, 8'd2, 25'h0, 16'h1234, 1'b0, 16'h1234, 2'b11, 1'b0};
		table_rows[2]  = '{K_CART_WORD, 8'd2, 25'h2, 16'hABCD, 1'b0, 16'hABCD, 2'b11, 1'b0};
		table_rows[3]  = '{K_CART_WORD, 8'd2, 25'h4, 16'h5A0F, 1'b0, 16'h5A0F, 2'b11, 1'b0};
		table_rows[4]  = '{K_CART_WORD, 8'd2, 25'h6, 16'h8001, 1'b1, 16'h0180, 2'b11, 1'b0};
		table_rows[5]  = '{K_CART_WORD, 8'd2, 25'h1F26, 16'hF20A, 1'b1, 16'h4F50, 2'b11, 1'b0};
		table_rows[6]  = '{K_CART_WORD, 8'd2, 25'h1F28, 16'hAA0A, 1'b1, 16'h5550, 2'b11, 1'b0};
		table_rows[7]  = '{K_CART_WORD, 8'd2, 25'h1F2A, 16'hF232, 1'b1, 16'h4F4C, 2'b11, 1'b0};
		table_rows[8]  = '{K_CART_WORD, 8'd2, 25'h1F2C, 16'hCAAA, 1'b1, 16'h5355, 2'b11, 1'b0};
		table_rows[9]  = '{K_CART_WORD, 8'd2, 25'h2126, 16'h1111, 1'b0, 16'h1111, 2'b01, 1'b0};
		table_rows[10] = '{K_CART_START, 8'd1, 25'h0, 16'h0, 1'b0, 16'h0, 2'b11, 1'b0};
		table_rows[11] = '{K_CODE_START, 8'hFF, 25'h0, 16'h0, 1'b0, 16'h0, 2'b11, 1'b0};
		for (int i = 0; i < 8; i++) begin
			table_rows[12+i] = '{K_CODE_WORD, 8'hFF, 25'(2*i), 16'hC000 | 16'(2*i),
				1'b0, 16'h0, 2'b11, (i == 7)};
		end
	endtask

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
	endtask

	// One cart write, then wait for the back-ends to release the host
	task automatic write_cart_word(input logic [24:0] addr, input logic [15:0] data,
			input logic swap, input logic [15:0] exp_data);
		logic req_before;
		logic [23:0] addr_before;
		@(negedge clk_sys);
		req_before  = rom_req;
		addr_before = rom_addr;
		ioctl_wr    = 1'b1;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		swap_bytes  = swap;
		#1;
		assert (rom_data == exp_data) else report_mismatch("rom_data", rom_data, exp_data);
		@(posedge clk_sys);
		#1;
		assert (ioctl_wait) else report_mismatch("ioctl_wait", ioctl_wait, 1);
		assert (rom_req != req_before) else report_mismatch("rom_req", rom_req, ~req_before);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			assert (ioctl_wait || (ack_ddr == rom_req && ack_sdr == rom_req))
				else report_mismatch("ioctl_wait", ioctl_wait, 1);
			if (!ioctl_wait)
				break;
			assert (rom_addr == addr_before) else report_mismatch("rom_addr", rom_addr, addr_before);
		end
		assert (rom_addr == addr_before + 2)
			else report_mismatch("rom_addr", rom_addr, addr_before + 2);
	endtask

	task automatic write_code_word(input logic [24:0] addr, input logic [15:0] data,
			input logic exp_valid);
		@(negedge clk_sys);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(posedge clk_sys);
		#1;
		assert (code_valid == exp_valid) else report_mismatch("code_valid", code_valid, exp_valid);
		assert (code_reset == (addr == 0))
			else report_mismatch("code_reset", code_reset, addr == 0);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin : main
		int writes;
		void'($urandom(32'h9556));
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		swap_bytes = 1'b0;
		load_table();

		// Count filler writes so the timeout covers the whole stream
		writes = ROWS;
		model_addr = '0;
		foreach (table_rows[i]) begin
			if (table_rows[i].kind == K_CART_START)
				model_addr = '0;
			else if (table_rows[i].kind == K_CART_WORD) begin
				writes += (table_rows[i].addr[23:0] - model_addr) / 2;
				model_addr = table_rows[i].addr[23:0] + 2;
			end
		end
		cycle_limit = writes * 12 + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
		assert (!ioctl_wait && !rom_req && rom_addr == 0 && pop_flags == 2'b00 && !sgx &&
			!code_valid && !code_reset) else begin
			$display("Outputs not in their reset state after rst");
			$display("** FAIL **");
			$fatal(1, "reset state");
		end

		foreach (table_rows[i]) begin
			case (table_rows[i].kind)
				K_CART_START, K_CODE_START: begin
					start_download(table_rows[i].index);
					@(posedge clk_sys);
					#1;
					if (table_rows[i].kind == K_CART_START) begin
						assert (rom_addr == 0) else report_mismatch("rom_addr", rom_addr, 0);
						assert (pop_flags == 2'b11) else report_mismatch("pop_flags", pop_flags, 3);
						assert (sgx == table_rows[i].exp_bit)
							else report_mismatch("sgx", sgx, table_rows[i].exp_bit);
					end
				end
				K_CART_WORD: begin
					while (rom_addr != table_rows[i].addr[23:0])
						write_cart_word({1'b0, rom_addr}, 16'h0000, 1'b0, 16'h0000);
					write_cart_word(table_rows[i].addr, table_rows[i].data,
						table_rows[i].swap, table_rows[i].exp_data);
					assert (pop_flags == table_rows[i].exp_flags)
						else report_mismatch("pop_flags", pop_flags, table_rows[i].exp_flags);
				end
				default: begin
					write_code_word(table_rows[i].addr, table_rows[i].data, table_rows[i].exp_bit);
				end
			endcase
		end

		// Slot rule gives flags {@2,@0}, address {@6,@4}, compare {@10,@8}, replace {@14,@12}
		assert (code.field.flags == 32'hC002_C000)
			else report_mismatch("code.flags", code.field.flags, 32'hC002_C000);
		assert (code.field.address == 32'hC006_C004)
			else report_mismatch("code.address", code.field.address, 32'hC006_C004);
		assert (code.field.compare == 32'hC00A_C008)
			else report_mismatch("code.compare", code.field.compare, 32'hC00A_C008);
		assert (code.field.replace == 32'hC00E_C00C)
			else report_mismatch("code.replace", code.field.replace, 32'hC00E_C00C);
		repeat (2) @(posedge clk_sys);
		assert (valid_count == 1) else report_mismatch("code_valid count", valid_count, 1);

		$display("** PASS **");
		$finish;
	end

endmodule
